//--- tcb_pkg.sv
// TCB bus package
// widths, response latency, endianness and status encodings
// shared by the converter, the delay pipeline and the memory

package tcb_pkg;

  ////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////

  // address and data width in bits
  localparam int unsigned TCB_ADR = 32;
  localparam int unsigned TCB_DAT = 32;
  // lane (unit) width and number of byte lanes
  localparam int unsigned TCB_UNT = 8;
  localparam int unsigned TCB_BEN = TCB_DAT / TCB_UNT;
  // address offset inside a word
  localparam int unsigned TCB_OFF = $clog2(TCB_BEN);
  // log size field, 0/1/2 for 1/2/4 bytes
  localparam int unsigned TCB_SIZ = 2;
  // low address bits cleared toward the memory
  localparam int unsigned TCB_ALN = 2;

  ////////////////////////////////////////////////////////////
  // timing
  ////////////////////////////////////////////////////////////

  // cycles from transfer to response
  localparam int unsigned TCB_DLY = 1;

  ////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////

  // endianness bit
  localparam logic TCB_LITTLE = 1'b0;
  localparam logic TCB_BIG    = 1'b1;

  // response status
  localparam logic TCB_STS_OK  = 1'b0;
  localparam logic TCB_STS_ERR = 1'b1;

endpackage : tcb_pkg

//--- tcb_mem_pkg.sv
// byte-enable memory package
// depth, word index width and initial content of the memory

package tcb_mem_pkg;

  ////////////////////////////////////////////////////////////
  // geometry
  ////////////////////////////////////////////////////////////

  // number of 32-bit words
  localparam int unsigned MEM_WORDS = 64;

  // word index width
  localparam int unsigned MEM_AW = $clog2(MEM_WORDS);

  ////////////////////////////////////////////////////////////
  // content
  ////////////////////////////////////////////////////////////

  // value read back from words never written
  localparam logic [31:0] MEM_FILL = 32'h0;

endpackage : tcb_mem_pkg

//--- tcb_dly_pipe.sv
// TCB response delay pipeline
// carries offset and endianness of each transfer up to its response cycle

`timescale 1ns/100ps

module tcb_dly_pipe (
  input  logic                        clk,
  input  logic                        rst_n,
  // request handshake
  input  logic                        vld,
  input  logic                        rdy,
  // request side fields
  input  logic [tcb_pkg::TCB_OFF-1:0] off,
  input  logic                        ndn,
  // response-time copies
  output logic [tcb_pkg::TCB_OFF-1:0] dly_off,
  output logic                        dly_ndn
);

  import tcb_pkg::*;

  ////////////////////////////////////////////////////////////
  // shift chain
  ////////////////////////////////////////////////////////////

  // one entry per cycle of latency
  logic [TCB_OFF-1:0] off_q [TCB_DLY];
  logic               ndn_q [TCB_DLY];

  // transfer on this edge
  logic               trn;

  assign trn = vld & rdy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // offset 0, little endian
      for (int unsigned s = 0; s < TCB_DLY; s++) begin
        off_q[s] <= '0;
        ndn_q[s] <= TCB_LITTLE;
      end
    end else begin
      // first stage only loads on a transfer
      if (trn) begin
        off_q[0] <= off;
        ndn_q[0] <= ndn;
      end
      // later stages move every cycle
      for (int unsigned s = 1; s < TCB_DLY; s++) begin
        off_q[s] <= off_q[s-1];
        ndn_q[s] <= ndn_q[s-1];
      end
    end
  end

  // last stage lines up with the response
  assign dly_off = off_q[TCB_DLY-1];
  assign dly_ndn = ndn_q[TCB_DLY-1];

endmodule : tcb_dly_pipe

//--- tcb_lib_logsize2byteena.sv
// TCB log size to byte enable converter
// masks the aligned address bits, expands size into byte enables and
// rotates lanes by the address offset for little or big endian

`timescale 1ns/100ps

module tcb_lib_logsize2byteena (
  // manager side request
  input  logic                        vld,
  input  logic                        cmd,
  input  logic                        wen,
  input  logic [tcb_pkg::TCB_ADR-1:0] adr,
  input  logic [tcb_pkg::TCB_SIZ-1:0] siz,
  input  logic                        ndn,
  input  logic [tcb_pkg::TCB_DAT-1:0] wdt,
  // manager side response
  output logic                        rdy,
  output logic [tcb_pkg::TCB_DAT-1:0] rdt,
  output logic                        sts,
  // offset and endianness of the transfer now answered
  input  logic [tcb_pkg::TCB_OFF-1:0] dly_off,
  input  logic                        dly_ndn,
  // memory side request
  output logic                        mem_vld,
  output logic                        mem_cmd,
  output logic                        mem_wen,
  output logic [tcb_pkg::TCB_ADR-1:0] mem_adr,
  output logic [tcb_pkg::TCB_BEN-1:0] mem_ben,
  output logic [tcb_pkg::TCB_DAT-1:0] mem_wdt,
  // memory side response
  input  logic                        mem_rdy,
  input  logic [tcb_pkg::TCB_DAT-1:0] mem_rdt,
  input  logic                        mem_sts
);

  import tcb_pkg::*;

  ////////////////////////////////////////////////////////////
  // lane index mapping
  ////////////////////////////////////////////////////////////

  // source lane for a given destination lane
  // little endian is a rotation, inverted on the way back
  // big endian is a reflection around the offset, its own inverse
  function automatic logic [TCB_OFF-1:0] lane_src(
    input logic [TCB_OFF-1:0] lane,
    input logic [TCB_OFF-1:0] off,
    input logic               end_big,
    input logic               back
  );
    logic [TCB_OFF-1:0] src;
    if (end_big == TCB_BIG) begin
      src = off - lane;
    end else if (back) begin
      src = lane + off;
    end else begin
      src = lane - off;
    end
    return src;
  endfunction : lane_src

  ////////////////////////////////////////////////////////////
  // local signals
  ////////////////////////////////////////////////////////////

  // request offset, low address bits
  logic [TCB_OFF-1:0]              req_off;
  // unrotated enables from size
  logic [TCB_BEN-1:0]              req_ben;
  // lane views of the data words
  logic [TCB_BEN-1:0][TCB_UNT-1:0] req_wdt;
  logic [TCB_BEN-1:0][TCB_UNT-1:0] man_wdt;
  logic [TCB_BEN-1:0][TCB_UNT-1:0] man_rdt;
  logic [TCB_BEN-1:0][TCB_UNT-1:0] rsp_rdt;

  assign req_off = adr[TCB_OFF-1:0];
  assign req_wdt = wdt;
  assign man_rdt = mem_rdt;

  ////////////////////////////////////////////////////////////
  // request control
  ////////////////////////////////////////////////////////////

  assign mem_vld = vld;
  assign mem_cmd = cmd;
  assign mem_wen = wen;

  // word aligned address toward the memory
  assign mem_adr = {adr[TCB_ADR-1:TCB_ALN], {TCB_ALN{1'b0}}};

  ////////////////////////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////////////////////////

  // lanes below 2**siz are active
  always_comb begin
    for (int unsigned i = 0; i < TCB_BEN; i++) begin
      req_ben[i] = (i < (32'd1 << siz));
    end
  end

  ////////////////////////////////////////////////////////////
  // request lane rotation
  ////////////////////////////////////////////////////////////

  // enables and write data share one mapping
  always_comb begin
    logic [TCB_OFF-1:0] src;
    for (int unsigned i = 0; i < TCB_BEN; i++) begin
      src        = lane_src(TCB_OFF'(i), req_off, ndn, 1'b0);
      mem_ben[i] = req_ben[src];
      man_wdt[i] = req_wdt[src];
    end
  end

  assign mem_wdt = man_wdt;

  ////////////////////////////////////////////////////////////
  // response lane rotation
  ////////////////////////////////////////////////////////////

  // uses the delayed offset and endianness of the answered transfer
  always_comb begin
    logic [TCB_OFF-1:0] src;
    for (int unsigned i = 0; i < TCB_BEN; i++) begin
      src        = lane_src(TCB_OFF'(i), dly_off, dly_ndn, 1'b1);
      rsp_rdt[i] = man_rdt[src];
    end
  end

  assign rdt = rsp_rdt;

  ////////////////////////////////////////////////////////////
  // status and handshake
  ////////////////////////////////////////////////////////////

  assign sts = mem_sts;
  assign rdy = mem_rdy;

endmodule : tcb_lib_logsize2byteena

//--- tcb_mem_byteena.sv
// TCB byte-enable memory
// 64 words with per-lane write mask, fixed read latency and error status
// for addresses past the end of the array or command transfers

`timescale 1ns/100ps

module tcb_mem_byteena (
  input  logic                        clk,
  input  logic                        rst_n,
  // request
  input  logic                        mem_vld,
  input  logic                        mem_cmd,
  input  logic                        mem_wen,
  input  logic [tcb_pkg::TCB_ADR-1:0] mem_adr,
  input  logic [tcb_pkg::TCB_BEN-1:0] mem_ben,
  input  logic [tcb_pkg::TCB_DAT-1:0] mem_wdt,
  // response
  output logic                        mem_rdy,
  output logic [tcb_pkg::TCB_DAT-1:0] mem_rdt,
  output logic                        mem_sts
);

  import tcb_pkg::*;
  import tcb_mem_pkg::*;

  ////////////////////////////////////////////////////////////
  // storage and decode
  ////////////////////////////////////////////////////////////

  logic [TCB_BEN-1:0][TCB_UNT-1:0] mem [MEM_WORDS];

  // full word index and array index
  logic [TCB_ADR-TCB_ALN-1:0]      wrd;
  logic [MEM_AW-1:0]               idx;
  logic [TCB_BEN-1:0][TCB_UNT-1:0] wdt;
  logic                            rdy_q;
  logic                            trn;
  logic                            hit;
  logic                            acc;

  // response pipeline
  logic [TCB_DAT-1:0]              rdt_q [TCB_DLY];
  logic                            sts_q [TCB_DLY];

  assign wdt = mem_wdt;
  assign wrd = mem_adr[TCB_ADR-1:TCB_ALN];
  assign idx = wrd[MEM_AW-1:0];
  assign trn = mem_vld & rdy_q;
  assign hit = (wrd < MEM_WORDS);
  // command transfers are not served, only plain data accesses
  assign acc = trn & hit & ~mem_cmd;

  // unwritten words read back as the fill value
  initial begin
    for (int unsigned w = 0; w < MEM_WORDS; w++) begin
      mem[w] = MEM_FILL;
    end
  end

  ////////////////////////////////////////////////////////////
  // write with lane mask
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (acc && mem_wen) begin
      for (int unsigned b = 0; b < TCB_BEN; b++) begin
        if (mem_ben[b]) begin
          mem[idx][b] <= wdt[b];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read data
  ////////////////////////////////////////////////////////////

  // old word on the transfer edge, fill value when out of range
  always_ff @(posedge clk) begin
    if (trn) begin
      rdt_q[0] <= acc ? mem[idx] : MEM_FILL;
    end
    for (int unsigned s = 1; s < TCB_DLY; s++) begin
      rdt_q[s] <= rdt_q[s-1];
    end
  end

  ////////////////////////////////////////////////////////////
  // ready and status
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdy_q <= 1'b0;
      for (int unsigned s = 0; s < TCB_DLY; s++) begin
        sts_q[s] <= TCB_STS_OK;
      end
    end else begin
      // ready one cycle after reset release
      rdy_q    <= 1'b1;
      // error flagged only in the response slot of a bad transfer
      sts_q[0] <= (trn && !acc) ? TCB_STS_ERR : TCB_STS_OK;
      for (int unsigned s = 1; s < TCB_DLY; s++) begin
        sts_q[s] <= sts_q[s-1];
      end
    end
  end

  assign mem_rdy = rdy_q;
  assign mem_rdt = rdt_q[TCB_DLY-1];
  assign mem_sts = sts_q[TCB_DLY-1];

endmodule : tcb_mem_byteena

//--- tcb_sub_top.sv
// TCB subsystem top
// log size manager bus into converter, delay pipeline and byte-enable memory

`timescale 1ns/100ps

module tcb_sub_top (
  input  logic                        clk,
  input  logic                        rst_n,
  // manager side request
  input  logic                        vld,
  input  logic                        cmd,
  input  logic                        wen,
  input  logic [tcb_pkg::TCB_ADR-1:0] adr,
  input  logic [tcb_pkg::TCB_SIZ-1:0] siz,
  input  logic                        ndn,
  input  logic [tcb_pkg::TCB_DAT-1:0] wdt,
  // manager side response
  output logic                        rdy,
  output logic [tcb_pkg::TCB_DAT-1:0] rdt,
  output logic                        sts
);

  import tcb_pkg::*;

  ////////////////////////////////////////////////////////////
  // internal wires
  ////////////////////////////////////////////////////////////

  // delayed transfer attributes
  logic [TCB_OFF-1:0] dly_off;
  logic               dly_ndn;

  // byte-enable bus to the memory
  logic               mem_vld;
  logic               mem_cmd;
  logic               mem_wen;
  logic [TCB_ADR-1:0] mem_adr;
  logic [TCB_BEN-1:0] mem_ben;
  logic [TCB_DAT-1:0] mem_wdt;
  logic               mem_rdy;
  logic [TCB_DAT-1:0] mem_rdt;
  logic               mem_sts;

  ////////////////////////////////////////////////////////////
  // instances
  ////////////////////////////////////////////////////////////

  tcb_dly_pipe dly (
    .clk     (clk),
    .rst_n   (rst_n),
    .vld     (vld),
    .rdy     (rdy),
    .off     (adr[TCB_OFF-1:0]),
    .ndn     (ndn),
    .dly_off (dly_off),
    .dly_ndn (dly_ndn)
  );

  tcb_lib_logsize2byteena cnv (
    .vld     (vld),
    .cmd     (cmd),
    .wen     (wen),
    .adr     (adr),
    .siz     (siz),
    .ndn     (ndn),
    .wdt     (wdt),
    .rdy     (rdy),
    .rdt     (rdt),
    .sts     (sts),
    .dly_off (dly_off),
    .dly_ndn (dly_ndn),
    .mem_vld (mem_vld),
    .mem_cmd (mem_cmd),
    .mem_wen (mem_wen),
    .mem_adr (mem_adr),
    .mem_ben (mem_ben),
    .mem_wdt (mem_wdt),
    .mem_rdy (mem_rdy),
    .mem_rdt (mem_rdt),
    .mem_sts (mem_sts)
  );

  tcb_mem_byteena mem (
    .clk     (clk),
    .rst_n   (rst_n),
    .mem_vld (mem_vld),
    .mem_cmd (mem_cmd),
    .mem_wen (mem_wen),
    .mem_adr (mem_adr),
    .mem_ben (mem_ben),
    .mem_wdt (mem_wdt),
    .mem_rdy (mem_rdy),
    .mem_rdt (mem_rdt),
    .mem_sts (mem_sts)
  );

endmodule : tcb_sub_top

//--- tcb_sub_assert.sv
// TCB subsystem checker
// concurrent assertions on alignment, byte enables, lane routing and response latency

`timescale 1ns/100ps

module tcb_sub_assert (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        vld,
  input  logic                        cmd,
  input  logic                        wen,
  input  logic                        rdy,
  input  logic [tcb_pkg::TCB_ADR-1:0] adr,
  input  logic [tcb_pkg::TCB_SIZ-1:0] siz,
  input  logic                        ndn,
  input  logic [tcb_pkg::TCB_DAT-1:0] wdt,
  input  logic [tcb_pkg::TCB_ADR-1:0] mem_adr,
  input  logic [tcb_pkg::TCB_BEN-1:0] mem_ben,
  input  logic [tcb_pkg::TCB_DAT-1:0] mem_wdt,
  input  logic                        sts
);

  import tcb_pkg::*;
  import tcb_mem_pkg::*;

  // failed assertions so far
  int unsigned fail_cnt = 0;
  logic        in_rng;

  // word index inside the memory
  assign in_rng = (32'(adr >> TCB_ALN) < MEM_WORDS);

  // bus byte j lands in lane off+j, or off-j in big endian
  function automatic int unsigned lane_of(int unsigned j, int unsigned off, logic big);
    if (big == TCB_BIG) begin
      return (off + TCB_BEN - j) % TCB_BEN;
    end
    return (off + j) % TCB_BEN;
  endfunction

  function automatic logic [TCB_BEN-1:0] ben_exp(logic [TCB_SIZ-1:0] s,
                                                 logic [TCB_OFF-1:0] off, logic big);
    logic [TCB_BEN-1:0] ben;
    ben = '0;
    for (int unsigned j = 0; j < (32'd1 << s); j++) begin
      ben[lane_of(j, off, big)] = 1'b1;
    end
    return ben;
  endfunction

  // every active byte of wdt sits in its own lane of mem_wdt
  function automatic logic wdt_placed(logic [TCB_DAT-1:0] src, logic [TCB_DAT-1:0] dst,
                                      logic [TCB_SIZ-1:0] s, logic [TCB_OFF-1:0] off,
                                      logic big);
    int unsigned lane;
    logic        ok;
    ok = 1'b1;
    for (int unsigned j = 0; j < (32'd1 << s); j++) begin
      lane = lane_of(j, off, big);
      if (dst[lane*TCB_UNT +: TCB_UNT] !== src[j*TCB_UNT +: TCB_UNT]) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  ////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////

  a_align: assert property (@(posedge clk) disable iff (!rst_n)
    vld |-> (mem_adr[TCB_ALN-1:0] == '0) &&
            (mem_adr[TCB_ADR-1:TCB_ALN] == adr[TCB_ADR-1:TCB_ALN]))
    else begin
      fail_cnt++;
      $error("mem_adr is not the word aligned request address");
    end

  a_ben: assert property (@(posedge clk) disable iff (!rst_n)
    vld && rdy |-> ($countones(mem_ben) == (1 << siz)) &&
                   (mem_ben == ben_exp(siz, adr[TCB_OFF-1:0], ndn)))
    else begin
      fail_cnt++;
      $error("mem_ben does not match size and offset");
    end

  a_wdt: assert property (@(posedge clk) disable iff (!rst_n)
    vld && rdy && wen |-> wdt_placed(wdt, mem_wdt, siz, adr[TCB_OFF-1:0], ndn))
    else begin
      fail_cnt++;
      $error("write data byte in the wrong lane");
    end

  ////////////////////////////////////////////////////////////
  // handshake and response
  ////////////////////////////////////////////////////////////

  // first cycle out of reset still not ready
  a_rst_rdy: assert property (@(posedge clk) $rose(rst_n) |-> !rdy)
    else begin
      fail_cnt++;
      $error("rdy high in the first cycle after reset");
    end

  a_sts_ok: assert property (@(posedge clk) disable iff (!rst_n)
    vld && rdy && !cmd && in_rng |-> ##TCB_DLY (sts == TCB_STS_OK))
    else begin
      fail_cnt++;
      $error("in range transfer answered with error status");
    end

  a_sts_err: assert property (@(posedge clk) disable iff (!rst_n)
    vld && rdy && !in_rng |-> ##TCB_DLY (sts == TCB_STS_ERR))
    else begin
      fail_cnt++;
      $error("out of range transfer not answered with error status");
    end

endmodule : tcb_sub_assert

//--- tcb_sub_tb.sv
// TCB subsystem testbench
// directed and random transfers checked against a byte-wide reference memory

`timescale 1ns/100ps

module tcb_sub_tb;

  import tcb_pkg::*;
  import tcb_mem_pkg::*;

  localparam int unsigned CLK_NS  = 4;
  localparam int unsigned RST_CYC = 2;
  localparam int unsigned N_RND   = 64;
  localparam int unsigned HS_MAX  = 16;
  // reset read, two sets of 24 size/offset transfers, random run, range checks
  localparam int unsigned N_XFER  = 1 + 24 + 24 + N_RND + 3;
  localparam int unsigned WDOG_NS = N_XFER * CLK_NS * 4 + RST_CYC * CLK_NS;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               vld;
  logic               cmd;
  logic               wen;
  logic [TCB_ADR-1:0] adr;
  logic [TCB_SIZ-1:0] siz;
  logic               ndn;
  logic [TCB_DAT-1:0] wdt;
  logic               rdy;
  logic [TCB_DAT-1:0] rdt;
  logic               sts;

  // reference memory, one entry per byte
  logic [TCB_UNT-1:0] ref_mem [MEM_WORDS*TCB_BEN];
  // responses in flight
  int unsigned        due_q [$];
  logic [TCB_DAT-1:0] rdt_q [$];
  logic               sts_q [$];
  logic               chk_q [$];
  int unsigned        cyc = 0;
  int unsigned        errs = 0;
  int unsigned        mark = 0;
  int unsigned        n_tests = 0;
  int unsigned        n_failed = 0;
  string              cur_test = "reset_ready";

  always #(CLK_NS/2) clk = ~clk;

  tcb_sub_top dut (
    .clk   (clk),
    .rst_n (rst_n),
    .vld   (vld),
    .cmd   (cmd),
    .wen   (wen),
    .adr   (adr),
    .siz   (siz),
    .ndn   (ndn),
    .wdt   (wdt),
    .rdy   (rdy),
    .rdt   (rdt),
    .sts   (sts)
  );

  bind tcb_sub_top tcb_sub_assert chk (
    .clk (clk), .rst_n (rst_n), .vld (vld), .cmd (cmd), .wen (wen), .rdy (rdy),
    .adr (adr), .siz (siz), .ndn (ndn), .wdt (wdt), .mem_adr (mem_adr),
    .mem_ben (mem_ben), .mem_wdt (mem_wdt), .sts (sts)
  );

  // bus byte j lives in byte off+j of the word, off-j in big endian
  function automatic int unsigned lane_of(int unsigned j, int unsigned off, logic big);
    if (big == TCB_BIG) begin
      return (off + TCB_BEN - j) % TCB_BEN;
    end
    return (off + j) % TCB_BEN;
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////

  // present one request and return on the edge that takes it
  task automatic send(logic w, logic [TCB_ADR-1:0] a, logic [TCB_SIZ-1:0] s, logic big,
                      logic [TCB_DAT-1:0] d);
    int unsigned n;
    vld <= 1'b1;
    cmd <= 1'b0;
    wen <= w;
    adr <= a;
    siz <= s;
    ndn <= big;
    wdt <= d;
    n = 0;
    @(negedge clk);
    while (!rdy && n < HS_MAX) begin
      n++;
      @(negedge clk);
    end
    if (!rdy) begin
      $display("rdy stayed low for %0d cycles in test %s", HS_MAX, cur_test);
      errs++;
    end
    @(posedge clk);
  endtask

  task automatic idle(int unsigned n);
    vld <= 1'b0;
    repeat (n) @(posedge clk);
  endtask

  task automatic end_test();
    int unsigned total;
    total = errs + dut.chk.fail_cnt;
    n_tests++;
    if (total == mark) begin
      $display("test %s: ok", cur_test);
    end else begin
      n_failed++;
      $display("test %s: %0d errors", cur_test, total - mark);
    end
    mark = total;
  endtask

  ////////////////////////////////////////////////////////////
  // response checker and model update
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    int unsigned        wrd;
    int unsigned        off;
    logic [TCB_DAT-1:0] e_rdt;
    logic               e_sts;
    logic               e_chk;
    cyc++;
    // no ready in reset nor in the cycle after
    if (cyc <= RST_CYC) begin
      assert (rdy === 1'b0) else begin
        $display("FAILED %s rdy expected 0 actual %b", cur_test, rdy);
        errs++;
      end
    end
    if (due_q.size() > 0 && due_q[0] == cyc) begin
      void'(due_q.pop_front());
      e_rdt = rdt_q.pop_front();
      e_sts = sts_q.pop_front();
      e_chk = chk_q.pop_front();
      assert (sts === e_sts) else begin
        $display("FAILED %s sts expected %b actual %b", cur_test, e_sts, sts);
        errs++;
      end
      if (e_chk) begin
        assert (rdt === e_rdt) else begin
          $display("FAILED %s rdt expected %h actual %h", cur_test, e_rdt, rdt);
          errs++;
        end
      end
    end
    // transfer on the coming edge
    if (vld && rdy) begin
      wrd = 32'(adr >> TCB_ALN);
      off = 32'(adr[TCB_OFF-1:0]);
      e_rdt = '0;
      if (wrd < MEM_WORDS) begin
        // old word, then the write
        for (int unsigned j = 0; j < TCB_BEN; j++) begin
          e_rdt[j*TCB_UNT +: TCB_UNT] = ref_mem[wrd*TCB_BEN + lane_of(j, off, ndn)];
        end
        if (wen) begin
          for (int unsigned j = 0; j < (32'd1 << siz); j++) begin
            ref_mem[wrd*TCB_BEN + lane_of(j, off, ndn)] = wdt[j*TCB_UNT +: TCB_UNT];
          end
        end
      end
      due_q.push_back(cyc + TCB_DLY);
      rdt_q.push_back(e_rdt);
      sts_q.push_back((wrd < MEM_WORDS) ? TCB_STS_OK : TCB_STS_ERR);
      chk_q.push_back(!wen && (wrd < MEM_WORDS));
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [TCB_ADR-1:0] a;
    int unsigned        total;
    void'($urandom(32'h77a));
    for (int unsigned b = 0; b < MEM_WORDS*TCB_BEN; b++) begin
      ref_mem[b] = MEM_FILL[(b % TCB_BEN)*TCB_UNT +: TCB_UNT];
    end
    // a read waits at the bus from time 0
    rst_n = 1'b0;
    vld   = 1'b1;
    cmd   = 1'b0;
    wen   = 1'b0;
    adr   = '0;
    siz   = 2'd2;
    ndn   = TCB_LITTLE;
    wdt   = '0;
    repeat (RST_CYC) @(posedge clk);
    rst_n <= 1'b1;
    send(1'b0, 32'h0, 2'd2, TCB_LITTLE, 32'h0);
    idle(TCB_DLY + 1);
    end_test();

    // each size and offset, its own word, read back whole
    for (int unsigned e = 0; e < 2; e++) begin
      cur_test = (e == 0) ? "le_sizes" : "be_sizes";
      for (int unsigned s = 0; s < 3; s++) begin
        for (int unsigned o = 0; o < TCB_BEN; o++) begin
          a = ((e*16 + s*TCB_BEN + o + 1) << TCB_ALN) | o;
          send(1'b1, a, 2'(s), 1'(e), $urandom());
          send(1'b0, a, 2'd2, 1'(e), 32'h0);
        end
      end
      idle(TCB_DLY + 1);
      end_test();
    end

    // back to back, endianness flips every transfer
    cur_test = "pipelined_mixed";
    for (int unsigned i = 0; i < N_RND; i++) begin
      a = (($urandom() % 16) << TCB_ALN) | ($urandom() % TCB_BEN);
      send(1'($urandom() % 2), a, 2'($urandom() % 3), 1'(i % 2), $urandom());
    end
    idle(TCB_DLY + 1);
    end_test();

    // word 64 aliases word 0 if the range check fails
    cur_test = "out_of_range";
    send(1'b1, 32'h0000_0101, 2'd2, TCB_LITTLE, 32'ha5a5_5a5a);
    send(1'b0, 32'h8000_0002, 2'd1, TCB_BIG, 32'h0);
    send(1'b0, 32'h0000_0001, 2'd2, TCB_LITTLE, 32'h0);
    idle(TCB_DLY + 1);
    end_test();

    total = errs + dut.chk.fail_cnt;
    $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, total);
    if (total == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WDOG_NS);
    $display("watchdog expired after %0d ns in test %s", WDOG_NS, cur_test);
    $display("Simulation failed");
    $finish;
  end

endmodule : tcb_sub_tb

//--- all.f
tcb_pkg.sv
tcb_mem_pkg.sv
tcb_dly_pipe.sv
tcb_lib_logsize2byteena.sv
tcb_mem_byteena.sv
tcb_sub_top.sv
tcb_sub_assert.sv
tcb_sub_tb.sv

//--- Makefile
# Verilator build and run of the TCB subsystem testbench

SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tcb_sub_tb
FLIST    := all.f
OBJ      := obj_dir
RUN_ARGS := +verilator+error+limit+1000
PASS     := Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJ)
